// ==== logic/ntt_cfg_pkg.sv ====
package ntt_cfg_pkg;

    // memory init wait, in cycles after reset
    localparam int DEGREE = 16;

    // accepted butterflies that close one iteration phase
    localparam int BU_PER_STAGE = 32;

    // group counts per iteration
    // ite0 runs as a single group
    localparam int ITE1_GROUPS = 16;
    localparam int ITE2_GROUPS = 2;

    // drain length is this value plus one
    localparam int DRAIN_CYCLES = 12;

    // width of all counters and of the depth index
    localparam int CNT_W = 8;

endpackage

// ==== logic/ntt_ctrl_pkg.sv ====
package ntt_ctrl_pkg;

    typedef enum logic [3:0] {
        ph_reset,
        ph_idle,
        ph_ite0,
        ph_drain0,
        ph_ite1,
        ph_drain1,
        ph_ite2,
        ph_drain2,
        ph_finish
    } ntt_phase_e;

    // butterflies are only accepted in these
    function automatic logic is_iteration(ntt_phase_e ph);
        return (ph == ph_ite0) || (ph == ph_ite1) || (ph == ph_ite2);
    endfunction

    function automatic logic is_drain(ntt_phase_e ph);
        return (ph == ph_drain0) || (ph == ph_drain1) || (ph == ph_drain2);
    endfunction

endpackage

// ==== logic/ntt_phase_fsm.sv ====
`timescale 1ns/1ps

module ntt_phase_fsm #(
    parameter int DEGREE       = ntt_cfg_pkg::DEGREE,
    parameter int BU_PER_STAGE = ntt_cfg_pkg::BU_PER_STAGE,
    parameter int DRAIN_CYCLES = ntt_cfg_pkg::DRAIN_CYCLES,
    parameter int CNT_W        = ntt_cfg_pkg::CNT_W
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stage_last,
    input  logic                     rd_done,
    input  logic                     bf_done,
    output ntt_ctrl_pkg::ntt_phase_e phase,
    output logic                     tf_init_base,
    output logic                     tf_init_const,
    output logic                     agu_enable,
    output logic                     wr_enable,
    output logic                     bf_enable,
    output logic                     finished
);

    ntt_ctrl_pkg::ntt_phase_e next_phase;

    logic [CNT_W-1:0] init_cnt;
    logic             init_done;
    logic [CNT_W-1:0] drain_cnt;
    logic             drain_done;
    logic [CNT_W-1:0] agu_cnt;
    logic             agu_window;
    logic             in_iter;
    logic             in_drain;

    assign init_done  = (init_cnt == CNT_W'(DEGREE));
    assign drain_done = (drain_cnt == CNT_W'(DRAIN_CYCLES));
    assign agu_window = (agu_cnt != CNT_W'(BU_PER_STAGE));
    assign in_iter    = ntt_ctrl_pkg::is_iteration(phase);
    assign in_drain   = ntt_ctrl_pkg::is_drain(phase);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= ntt_ctrl_pkg::ph_reset;
        end else begin
            phase <= next_phase;
        end
    end

    // init wait starts right after reset, then holds
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init_cnt <= '0;
        end else if (!init_done) begin
            init_cnt <= init_cnt + 1'b1;
        end
    end

    // drain timer, zero on the first drain cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            drain_cnt <= '0;
        end else if (in_drain && !drain_done) begin
            drain_cnt <= drain_cnt + 1'b1;
        end else begin
            drain_cnt <= '0;
        end
    end

    // address generator window, ite0 only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            agu_cnt <= '0;
        end else if (phase == ntt_ctrl_pkg::ph_ite0) begin
            if (agu_window) begin
                agu_cnt <= agu_cnt + 1'b1;
            end
        end else begin
            agu_cnt <= '0;
        end
    end

    always_comb begin
        next_phase = phase;
        case (phase)
            ntt_ctrl_pkg::ph_reset: begin
                next_phase = ntt_ctrl_pkg::ph_idle;
            end
            ntt_ctrl_pkg::ph_idle: begin
                if (init_done) begin
                    next_phase = ntt_ctrl_pkg::ph_ite0;
                end
            end
            ntt_ctrl_pkg::ph_ite0: begin
                if (stage_last) begin
                    next_phase = ntt_ctrl_pkg::ph_drain0;
                end
            end
            ntt_ctrl_pkg::ph_drain0: begin
                if (drain_done) begin
                    next_phase = ntt_ctrl_pkg::ph_ite1;
                end
            end
            ntt_ctrl_pkg::ph_ite1: begin
                if (stage_last) begin
                    next_phase = ntt_ctrl_pkg::ph_drain1;
                end
            end
            ntt_ctrl_pkg::ph_drain1: begin
                if (drain_done) begin
                    next_phase = ntt_ctrl_pkg::ph_ite2;
                end
            end
            ntt_ctrl_pkg::ph_ite2: begin
                if (stage_last) begin
                    next_phase = ntt_ctrl_pkg::ph_drain2;
                end
            end
            ntt_ctrl_pkg::ph_drain2: begin
                if (drain_done) begin
                    next_phase = ntt_ctrl_pkg::ph_finish;
                end
            end
            ntt_ctrl_pkg::ph_finish: begin
                next_phase = ntt_ctrl_pkg::ph_finish;
            end
            default: begin
                next_phase = ntt_ctrl_pkg::ph_reset;
            end
        endcase
    end

    // twiddle base and constant load during the init wait
    assign tf_init_base  = (phase == ntt_ctrl_pkg::ph_idle);
    assign tf_init_const = (phase == ntt_ctrl_pkg::ph_idle);

    always_comb begin
        case (phase)
            ntt_ctrl_pkg::ph_ite0: agu_enable = agu_window;
            ntt_ctrl_pkg::ph_ite1: agu_enable = 1'b1;
            ntt_ctrl_pkg::ph_ite2: agu_enable = 1'b1;
            default:               agu_enable = 1'b0;
        endcase
    end

    // write back stays open while the pipeline drains
    assign wr_enable = in_drain || (in_iter && bf_done);
    assign bf_enable = (in_iter || in_drain) && rd_done;
    assign finished  = (phase == ntt_ctrl_pkg::ph_finish);

endmodule

// ==== logic/twiddle_sched.sv ====
`timescale 1ns/1ps

module twiddle_sched #(
    parameter int BU_PER_STAGE = ntt_cfg_pkg::BU_PER_STAGE,
    parameter int ITE1_GROUPS  = ntt_cfg_pkg::ITE1_GROUPS,
    parameter int ITE2_GROUPS  = ntt_cfg_pkg::ITE2_GROUPS,
    parameter int CNT_W        = ntt_cfg_pkg::CNT_W
) (
    input  logic                     clk,
    input  logic                     rst,
    input  ntt_ctrl_pkg::ntt_phase_e phase,
    input  logic                     bn_out_valid,
    output logic                     tf_ren,
    output logic                     tf_wen,
    output logic [CNT_W-1:0]         tf_depth,
    output logic                     stage_last
);

    // butterflies per group in each iteration
    localparam int GRP1_SIZE = BU_PER_STAGE / ITE1_GROUPS;
    localparam int GRP2_SIZE = BU_PER_STAGE / ITE2_GROUPS;

    logic             in_iter;
    logic [CNT_W-1:0] bu_cnt;
    logic [CNT_W-1:0] grp_bu_cnt;
    logic [CNT_W-1:0] grp_size;
    logic             grp_last;

    assign in_iter = ntt_ctrl_pkg::is_iteration(phase);

    // one accepted butterfly per valid cycle
    assign tf_ren = in_iter && bn_out_valid;

    always_comb begin
        case (phase)
            ntt_ctrl_pkg::ph_ite1: grp_size = CNT_W'(GRP1_SIZE);
            ntt_ctrl_pkg::ph_ite2: grp_size = CNT_W'(GRP2_SIZE);
            default:               grp_size = CNT_W'(BU_PER_STAGE);
        endcase
    end

    assign stage_last = tf_ren && (bu_cnt == CNT_W'(BU_PER_STAGE - 1));
    assign grp_last   = tf_ren && (grp_bu_cnt == grp_size - 1'b1);

    // the final group ends with the phase, no twiddle update there
    assign tf_wen = grp_last && !stage_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bu_cnt     <= '0;
            grp_bu_cnt <= '0;
        end else if (!in_iter) begin
            bu_cnt     <= '0;
            grp_bu_cnt <= '0;
        end else if (tf_ren) begin
            if (stage_last) begin
                bu_cnt <= '0;
            end else begin
                bu_cnt <= bu_cnt + 1'b1;
            end
            if (grp_last) begin
                grp_bu_cnt <= '0;
            end else begin
                grp_bu_cnt <= grp_bu_cnt + 1'b1;
            end
        end
    end

    // depth index, ite2 alternates on a period of four
    always_comb begin
        tf_depth = '0;
        if (tf_ren) begin
            case (phase)
                ntt_ctrl_pkg::ph_ite1: begin
                    tf_depth = CNT_W'(1);
                end
                ntt_ctrl_pkg::ph_ite2: begin
                    case (bu_cnt[1:0])
                        2'd1:    tf_depth = CNT_W'(3);
                        2'd2:    tf_depth = CNT_W'(3);
                        default: tf_depth = CNT_W'(2);
                    endcase
                end
                default: begin
                    tf_depth = '0;
                end
            endcase
        end
    end

endmodule

// ==== logic/ntt_controller.sv ====
`timescale 1ns/1ps

module ntt_controller #(
    parameter int DEGREE       = ntt_cfg_pkg::DEGREE,
    parameter int BU_PER_STAGE = ntt_cfg_pkg::BU_PER_STAGE,
    parameter int ITE1_GROUPS  = ntt_cfg_pkg::ITE1_GROUPS,
    parameter int ITE2_GROUPS  = ntt_cfg_pkg::ITE2_GROUPS,
    parameter int DRAIN_CYCLES = ntt_cfg_pkg::DRAIN_CYCLES,
    parameter int CNT_W        = ntt_cfg_pkg::CNT_W
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             bn_out_valid,
    input  logic             rd_done,
    input  logic             bf_done,
    output logic             tf_init_base,
    output logic             tf_init_const,
    output logic             tf_ren,
    output logic             tf_wen,
    output logic [CNT_W-1:0] tf_depth,
    output logic             agu_enable,
    output logic             rd_enable,
    output logic             wr_enable,
    output logic             bf_enable,
    output logic             finished
);

    ntt_ctrl_pkg::ntt_phase_e phase;
    logic                     stage_last;

    ntt_phase_fsm #(
        .DEGREE       (DEGREE),
        .BU_PER_STAGE (BU_PER_STAGE),
        .DRAIN_CYCLES (DRAIN_CYCLES),
        .CNT_W        (CNT_W)
    ) u_fsm (
        .clk           (clk),
        .rst           (rst),
        .stage_last    (stage_last),
        .rd_done       (rd_done),
        .bf_done       (bf_done),
        .phase         (phase),
        .tf_init_base  (tf_init_base),
        .tf_init_const (tf_init_const),
        .agu_enable    (agu_enable),
        .wr_enable     (wr_enable),
        .bf_enable     (bf_enable),
        .finished      (finished)
    );

    twiddle_sched #(
        .BU_PER_STAGE (BU_PER_STAGE),
        .ITE1_GROUPS  (ITE1_GROUPS),
        .ITE2_GROUPS  (ITE2_GROUPS),
        .CNT_W        (CNT_W)
    ) u_twiddle (
        .clk          (clk),
        .rst          (rst),
        .phase        (phase),
        .bn_out_valid (bn_out_valid),
        .tf_ren       (tf_ren),
        .tf_wen       (tf_wen),
        .tf_depth     (tf_depth),
        .stage_last   (stage_last)
    );

    // memory read follows the twiddle read strobe
    assign rd_enable = tf_ren;

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

// ==== testbench/ntt_controller_sva.sv ====
`timescale 1ns/1ps

module ntt_controller_sva (
    input logic clk,
    input logic rst,
    input logic tf_ren,
    input logic tf_wen,
    input logic rd_enable,
    input logic finished
);

    int unsigned fail_cnt = 0;

    // a twiddle write rides on an accepted butterfly
    wen_needs_ren: assert property (@(posedge clk) disable iff (rst) tf_wen |-> tf_ren)
        else begin
            $error("tf_wen high without tf_ren");
            fail_cnt++;
        end

    rd_follows_ren: assert property (@(posedge clk) disable iff (rst) rd_enable == tf_ren)
        else begin
            $error("rd_enable differs from tf_ren");
            fail_cnt++;
        end

    // rest state is final
    finished_holds: assert property (@(posedge clk) disable iff (rst) finished |=> finished)
        else begin
            $error("finished dropped after rising");
            fail_cnt++;
        end

    no_ren_when_done: assert property (@(posedge clk) disable iff (rst) finished |-> !tf_ren)
        else begin
            $error("tf_ren high while finished");
            fail_cnt++;
        end

endmodule

bind ntt_controller ntt_controller_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .tf_ren    (tf_ren),
    .tf_wen    (tf_wen),
    .rd_enable (rd_enable),
    .finished  (finished)
);

// ==== testbench/ntt_controller_tb.sv ====
`timescale 1ns/1ps

module ntt_controller_tb;

    localparam int BU           = ntt_cfg_pkg::BU_PER_STAGE;
    localparam int DEGREE       = ntt_cfg_pkg::DEGREE;
    localparam int DRAIN_CYCLES = ntt_cfg_pkg::DRAIN_CYCLES;
    localparam int RST_CYCLES   = 4;
    localparam int WAIT_LIMIT   = 2000;

    logic                          clk;
    logic                          rst;
    logic                          bn_out_valid;
    logic                          rd_done;
    logic                          bf_done;
    logic                          tf_init_base;
    logic                          tf_init_const;
    logic                          tf_ren;
    logic                          tf_wen;
    logic [ntt_cfg_pkg::CNT_W-1:0] tf_depth;
    logic                          agu_enable;
    logic                          rd_enable;
    logic                          wr_enable;
    logic                          bf_enable;
    logic                          finished;

    logic [31:0] golden [0:31];
    int          n_gaps;
    int          gap_left;
    int          gap_idx;
    int          seed;
    int          mismatch_cnt;
    int          other_cnt;
    bit          aborted;

    tb_clock #(.PERIOD(8.0)) u_clk (.clk(clk));

    ntt_controller u_dut (
        .clk           (clk),
        .rst           (rst),
        .bn_out_valid  (bn_out_valid),
        .rd_done       (rd_done),
        .bf_done       (bf_done),
        .tf_init_base  (tf_init_base),
        .tf_init_const (tf_init_const),
        .tf_ren        (tf_ren),
        .tf_wen        (tf_wen),
        .tf_depth      (tf_depth),
        .agu_enable    (agu_enable),
        .rd_enable     (rd_enable),
        .wr_enable     (wr_enable),
        .bf_enable     (bf_enable),
        .finished      (finished)
    );

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
            mismatch_cnt++;
        end
    endtask

    task automatic expect_outputs(input logic init, input logic ren, input logic wen,
                                  input logic [31:0] depth, input logic agu, input logic wr,
                                  input logic bf, input logic fin);
        check_val("tf_init_base", tf_init_base, init);
        check_val("tf_init_const", tf_init_const, init);
        check_val("tf_ren", tf_ren, ren);
        check_val("rd_enable", rd_enable, ren);
        check_val("tf_wen", tf_wen, wen);
        check_val("tf_depth", tf_depth, depth);
        check_val("agu_enable", agu_enable, agu);
        check_val("wr_enable", wr_enable, wr);
        check_val("bf_enable", bf_enable, bf);
        check_val("finished", finished, fin);
    endtask

    task automatic timed_out(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        other_cnt++;
        aborted = 1'b1;
    endtask

    // one high cycle and then golden[1+idx] low cycles
    task automatic next_valid(output logic v);
        if (gap_left == 0) begin
            v = 1'b1;
            gap_left = golden[1 + gap_idx];
            gap_idx = (gap_idx + 1) % n_gaps;
        end else begin
            v = 1'b0;
            gap_left--;
        end
    endtask

    // drive 1 ns after the edge and return 2 ns before the next one
    task automatic step();
        logic [31:0] rnd;
        @(posedge clk);
        #1;
        next_valid(bn_out_valid);
        rnd = $random(seed);
        rd_done = rnd[0];
        rnd = $random(seed);
        bf_done = rnd[0];
        #5;
    endtask

    function automatic logic [31:0] depth_rule(input int p, input int idx);
        if (p == 0) return 0;
        if (p == 1) return 1;
        if ((idx % 4 == 1) || (idx % 4 == 2)) return 3;
        return 2;
    endfunction

    task automatic run_iter(input int p);
        int          acc;
        int          cyc;
        int          gsize;
        int          ren_n;
        int          wen_n;
        int          depth_n [4];
        int          base;
        logic        exp_wen;
        logic [31:0] exp_depth;
        acc = 0;
        cyc = 0;
        ren_n = 0;
        wen_n = 0;
        depth_n = '{0, 0, 0, 0};
        gsize = (p == 0) ? BU
              : BU / ((p == 1) ? ntt_cfg_pkg::ITE1_GROUPS : ntt_cfg_pkg::ITE2_GROUPS);
        while (!aborted && acc < BU) begin
            step();
            exp_wen = bn_out_valid && ((acc + 1) % gsize == 0) && (acc + 1 != BU);
            exp_depth = bn_out_valid ? depth_rule(p, acc) : 32'd0;
            expect_outputs(1'b0, bn_out_valid, exp_wen, exp_depth, (p != 0) || (cyc < BU),
                           bf_done, rd_done, 1'b0);
            ren_n += (tf_ren === 1'b1);
            wen_n += (tf_wen === 1'b1);
            if (tf_ren === 1'b1 && tf_depth < 4) depth_n[tf_depth]++;
            if (bn_out_valid) acc++;
            cyc++;
            if (cyc > WAIT_LIMIT) timed_out($sformatf("end of ite%0d", p));
        end
        if (!aborted) begin
            base = 1 + n_gaps + 6 * p;
            check_val($sformatf("ite%0d tf_ren count", p), ren_n, golden[base]);
            check_val($sformatf("ite%0d tf_wen count", p), wen_n, golden[base + 1]);
            check_val($sformatf("ite%0d tf_wen count by group rule", p), wen_n, BU / gsize - 1);
            for (int d = 0; d < 4; d++) begin
                check_val($sformatf("ite%0d depth %0d count", p, d), depth_n[d],
                          golden[base + 2 + d]);
            end
        end
    endtask

    task automatic finish_run();
        int sva_cnt;
        sva_cnt = u_dut.u_sva.fail_cnt;
        $display("errors: mismatch %0d, other %0d, assertion %0d",
                 mismatch_cnt, other_cnt, sva_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0 && sva_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin
        int  wait_cnt;
        bit  init_seen;
        rst = 1'b1;
        bn_out_valid = 1'b0;
        rd_done = 1'b0;
        bf_done = 1'b0;
        seed = 32'hddf0514f;
        gap_left = 0;
        gap_idx = 0;
        mismatch_cnt = 0;
        other_cnt = 0;
        aborted = 1'b0;
        $readmemh("testbench/ntt_controller_golden.txt", golden);
        n_gaps = golden[0];
        if ($isunknown(golden[0]) || n_gaps == 0 || n_gaps > 16) begin
            $display("The golden file could not be read or holds no gap values");
            other_cnt++;
            aborted = 1'b1;
        end
        // all outputs stay low through reset and the reset state even with inputs high
        for (int i = 0; i < RST_CYCLES && !aborted; i++) begin
            @(posedge clk);
            #1;
            if (i == RST_CYCLES - 1) rst = 1'b0;
            bn_out_valid = 1'b1;
            rd_done = 1'b1;
            bf_done = 1'b1;
            #5;
            expect_outputs(1'b0, 1'b0, 1'b0, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0);
        end
        wait_cnt = 0;
        init_seen = 1'b0;
        while (!aborted && !init_seen) begin
            step();
            init_seen = (tf_init_base === 1'b1);
            if (!init_seen) expect_outputs(1'b0, 1'b0, 1'b0, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT) timed_out("rise of tf_init_base");
        end
        if (!aborted) begin
            expect_outputs(1'b1, 1'b0, 1'b0, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0);
            repeat (DEGREE - 1) begin
                step();
                expect_outputs(1'b1, 1'b0, 1'b0, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0);
            end
        end
        for (int p = 0; p < 3 && !aborted; p++) begin
            run_iter(p);
            for (int c = 0; c <= DRAIN_CYCLES && !aborted; c++) begin
                step();
                expect_outputs(1'b0, 1'b0, 1'b0, 32'd0, 1'b0, 1'b1, rd_done, 1'b0);
            end
        end
        for (int c = 0; c <= 50 && !aborted; c++) begin
            step();
            expect_outputs(1'b0, 1'b0, 1'b0, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1);
        end
        finish_run();
    end

endmodule

// ==== testbench/ntt_controller_golden.txt ====
// gap count, then the gaps: low cycles of bn_out_valid after each high cycle
// then per phase ite0..ite2: tf_ren, tf_wen, depth0, depth1, depth2, depth3 counts
8
0 1 3 0 2 5 1 0
// ite0
20 0 20 0 0 0
// ite1
20 f 0 20 0 0
// ite2
20 1 0 0 10 10

// ==== all.f ====
logic/ntt_cfg_pkg.sv
logic/ntt_ctrl_pkg.sv
logic/ntt_phase_fsm.sv
logic/twiddle_sched.sv
logic/ntt_controller.sv
testbench/tb_clock.sv
testbench/ntt_controller_sva.sv
testbench/ntt_controller_tb.sv
